//--- source/kl10Pkg.sv
package kl10Pkg;

  // EBUS and diagnostic function widths
  localparam int ebusWidth = 36;
  localparam int funcWidth = 7;

  localparam int aprRegCount = 4;  // Diagnostic registers on the APR board

  // Priority interrupt board layout
  localparam int piLevels = 7;
  localparam int piEnableLsb = 8;  // Enable field in PI write and read words
  localparam int piLevelLsb = 16;  // Encoded level in PI read data
  localparam int piLevelWidth = 3;

  // Diagnostic function codes, anything not listed selects no board
  typedef enum logic [funcWidth-1:0] {
    fnAprWr0 = 7'o100,
    fnAprWr1 = 7'o101,
    fnAprWr2 = 7'o102,
    fnAprWr3 = 7'o103,
    fnAprRd0 = 7'o110,
    fnAprRd1 = 7'o111,
    fnAprRd2 = 7'o112,
    fnAprRd3 = 7'o113,
    fnPiWr   = 7'o120,
    fnPiRd   = 7'o130
  } tDiagFunc;

  // Front-end diagnostic cycle sequencer
  typedef enum logic [1:0] {
    idle   = 2'd0,
    setup  = 2'd1,
    strobe = 2'd2,
    finish = 2'd3
  } tFeState;

endpackage

//--- source/ebusFrontEnd.sv
module ebusFrontEnd (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          reqStart,
  input  logic                          reqWrite,
  input  logic [kl10Pkg::funcWidth-1:0] reqFunc,
  input  logic [kl10Pkg::ebusWidth-1:0] reqData,
  output logic                          busy,
  output logic                          done,
  output logic [kl10Pkg::ebusWidth-1:0] rdData,
  output logic [kl10Pkg::funcWidth-1:0] diagFunc,
  output logic                          diagRead,
  output logic                          diagStrobe,
  output logic [kl10Pkg::ebusWidth-1:0] feData,
  output logic                          feDriving,
  input  logic [kl10Pkg::ebusWidth-1:0] ebusData
);

  kl10Pkg::tFeState state;
  kl10Pkg::tFeState nextState;
  logic cycWrite;  // Direction of the cycle in progress
  logic accept;

  // Busy covers setup and strobe only, finish can already take the next start
  assign busy = (state == kl10Pkg::setup) || (state == kl10Pkg::strobe);
  assign accept = reqStart && !busy;

  assign done = (state == kl10Pkg::finish);
  assign diagStrobe = (state == kl10Pkg::strobe);
  assign diagRead = busy && !cycWrite;
  assign feDriving = busy && cycWrite;  // Write data sits on the bus through strobe

  always_comb begin
    nextState = state;
    case (state)
      kl10Pkg::idle: begin
        if (accept)
          nextState = kl10Pkg::setup;
      end
      kl10Pkg::setup:
        nextState = kl10Pkg::strobe;
      kl10Pkg::strobe:
        nextState = kl10Pkg::finish;
      kl10Pkg::finish: begin
        if (accept)
          nextState = kl10Pkg::setup;  // Back to back request
        else
          nextState = kl10Pkg::idle;
      end
      default:
        nextState = kl10Pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= kl10Pkg::idle;
      cycWrite <= 1'b0;
      diagFunc <= '0;
    end else begin
      state <= nextState;
      if (accept) begin
        cycWrite <= reqWrite;
        diagFunc <= reqFunc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      feData <= '0;
    else if (accept)
      feData <= reqData;
  end

  // Read data is taken off the bus at the end of the strobe cycle
  always_ff @(posedge clk) begin
    if (rst)
      rdData <= '0;
    else if (diagStrobe && !cycWrite)
      rdData <= ebusData;
  end

  strobeOnePulse: assert property (
    @(posedge clk) disable iff (rst)
    diagStrobe |=> !diagStrobe
  );

  doneAfterStrobe: assert property (
    @(posedge clk) disable iff (rst)
    done |-> $past(diagStrobe)
  );

endmodule

//--- source/aprDiagRegs.sv
module aprDiagRegs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [kl10Pkg::funcWidth-1:0] diagFunc,
  input  logic                          diagRead,
  input  logic                          diagStrobe,
  input  logic [kl10Pkg::ebusWidth-1:0] ebusData,
  output logic [kl10Pkg::ebusWidth-1:0] aprData,
  output logic                          aprDriving
);

  localparam int selWidth = $clog2(kl10Pkg::aprRegCount);

  logic [kl10Pkg::ebusWidth-1:0] aprReg [kl10Pkg::aprRegCount];
  logic [selWidth-1:0] wrSel;
  logic [selWidth-1:0] rdSel;
  logic wrHit;
  logic rdHit;

  // Function code decode
  always_comb begin
    wrHit = 1'b1;
    rdHit = 1'b1;
    wrSel = '0;
    rdSel = '0;
    case (diagFunc)
      kl10Pkg::fnAprWr0: wrSel = 2'd0;
      kl10Pkg::fnAprWr1: wrSel = 2'd1;
      kl10Pkg::fnAprWr2: wrSel = 2'd2;
      kl10Pkg::fnAprWr3: wrSel = 2'd3;
      default: wrHit = 1'b0;
    endcase
    case (diagFunc)
      kl10Pkg::fnAprRd0: rdSel = 2'd0;
      kl10Pkg::fnAprRd1: rdSel = 2'd1;
      kl10Pkg::fnAprRd2: rdSel = 2'd2;
      kl10Pkg::fnAprRd3: rdSel = 2'd3;
      default: rdHit = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < kl10Pkg::aprRegCount; i++) begin
        aprReg[i] <= '0;
      end
    end else if (diagStrobe && wrHit) begin
      aprReg[wrSel] <= ebusData;
    end
  end

  assign aprData = aprReg[rdSel];
  assign aprDriving = diagRead && rdHit;  // Only while the front end runs a read

  // A read drive begun in setup must still be on the bus for the strobe
  driveHeldToStrobe: assert property (
    @(posedge clk) disable iff (rst)
    (aprDriving && !diagStrobe) |=> (aprDriving && diagStrobe)
  );

endmodule

//--- source/piController.sv
module piController (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [kl10Pkg::funcWidth-1:0]    diagFunc,
  input  logic                             diagRead,
  input  logic                             diagStrobe,
  input  logic [kl10Pkg::ebusWidth-1:0]    ebusData,
  output logic [kl10Pkg::ebusWidth-1:0]    piData,
  output logic                             piDriving,
  output logic [kl10Pkg::piLevelWidth-1:0] piLevel
);

  logic [kl10Pkg::piLevels-1:0] piReq;
  logic [kl10Pkg::piLevels-1:0] piEn;
  logic [kl10Pkg::piLevels-1:0] piActive;
  logic piWrite;

  assign piWrite = diagStrobe && (diagFunc == kl10Pkg::fnPiWr);

  // Requests from the low field, enables from the enable field
  always_ff @(posedge clk) begin
    if (rst) begin
      piReq <= '0;
      piEn <= '0;
    end else if (piWrite) begin
      piReq <= ebusData[kl10Pkg::piLevels-1:0];
      piEn <= ebusData[kl10Pkg::piEnableLsb +: kl10Pkg::piLevels];
    end
  end

  assign piActive = piReq & piEn;

  // Bit 0 is level 1, the highest priority, so it is checked last and wins
  always_comb begin
    piLevel = '0;
    for (int i = kl10Pkg::piLevels - 1; i >= 0; i--) begin
      if (piActive[i])
        piLevel = kl10Pkg::piLevelWidth'(i + 1);
    end
  end

  always_comb begin
    piData = '0;
    piData[kl10Pkg::piLevels-1:0] = piActive;
    piData[kl10Pkg::piEnableLsb +: kl10Pkg::piLevels] = piEn;
    piData[kl10Pkg::piLevelLsb +: kl10Pkg::piLevelWidth] = piLevel;
  end

  assign piDriving = diagRead && (diagFunc == kl10Pkg::fnPiRd);

  // Level must name an active request
  levelIsActive: assert property (
    @(posedge clk) disable iff (rst)
    (piLevel != '0) |-> piActive[piLevel - 1'b1]
  );

endmodule

//--- source/ebusMux.sv
module ebusMux (
  input  logic [kl10Pkg::ebusWidth-1:0] feData,
  input  logic                          feDriving,
  input  logic [kl10Pkg::ebusWidth-1:0] aprData,
  input  logic                          aprDriving,
  input  logic [kl10Pkg::ebusWidth-1:0] piData,
  input  logic                          piDriving,
  output logic [kl10Pkg::ebusWidth-1:0] ebusData
);

  // First driver in line wins, idle bus reads as zero
  always_comb begin
    case (1'b1)
      feDriving:
        ebusData = feData;
      aprDriving:
        ebusData = aprData;
      piDriving:
        ebusData = piData;
      default:
        ebusData = '0;
    endcase
  end

  // Two boards on the bus at once means a decode overlap somewhere
  oneDriver: assert final ($onehot0({feDriving, aprDriving, piDriving}));

endmodule

//--- source/kl10Ebus.sv
module kl10Ebus (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             reqStart,
  input  logic                             reqWrite,
  input  logic [kl10Pkg::funcWidth-1:0]    reqFunc,
  input  logic [kl10Pkg::ebusWidth-1:0]    reqData,
  output logic                             busy,
  output logic                             done,
  output logic [kl10Pkg::ebusWidth-1:0]    rdData,
  output logic [kl10Pkg::piLevelWidth-1:0] piLevel
);

  logic [kl10Pkg::ebusWidth-1:0] ebusData;  // Mux output seen by every board
  logic [kl10Pkg::funcWidth-1:0] diagFunc;
  logic diagRead;
  logic diagStrobe;

  // Per-driver bus sources
  logic [kl10Pkg::ebusWidth-1:0] feData;
  logic feDriving;
  logic [kl10Pkg::ebusWidth-1:0] aprData;
  logic aprDriving;
  logic [kl10Pkg::ebusWidth-1:0] piData;
  logic piDriving;

  ebusFrontEnd frontEnd (
    .clk(clk),
    .rst(rst),
    .reqStart(reqStart),
    .reqWrite(reqWrite),
    .reqFunc(reqFunc),
    .reqData(reqData),
    .busy(busy),
    .done(done),
    .rdData(rdData),
    .diagFunc(diagFunc),
    .diagRead(diagRead),
    .diagStrobe(diagStrobe),
    .feData(feData),
    .feDriving(feDriving),
    .ebusData(ebusData)
  );

  aprDiagRegs apr (
    .clk(clk),
    .rst(rst),
    .diagFunc(diagFunc),
    .diagRead(diagRead),
    .diagStrobe(diagStrobe),
    .ebusData(ebusData),
    .aprData(aprData),
    .aprDriving(aprDriving)
  );

  piController pic (
    .clk(clk),
    .rst(rst),
    .diagFunc(diagFunc),
    .diagRead(diagRead),
    .diagStrobe(diagStrobe),
    .ebusData(ebusData),
    .piData(piData),
    .piDriving(piDriving),
    .piLevel(piLevel)
  );

  ebusMux mux (
    .feData(feData),
    .feDriving(feDriving),
    .aprData(aprData),
    .aprDriving(aprDriving),
    .piData(piData),
    .piDriving(piDriving),
    .ebusData(ebusData)
  );

endmodule

//--- testbench/kl10EbusTb.sv
module kl10EbusTb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [kl10Pkg::ebusWidth-1:0] tWord;
  typedef logic [kl10Pkg::funcWidth-1:0] tFunc;

  localparam int resetCycles = 8;
  localparam int aprRounds = 3;
  localparam int piRounds = 8;
  localparam int junkCount = 4;
  localparam int totalRequests = 5 + aprRounds * 8 + (piRounds + 1) * 2 + junkCount * 3 + 5 + 2;
  localparam int timeoutCycles = totalRequests * 4 + resetCycles + 40;

  logic clk;
  logic rst;
  logic reqStart;
  logic reqWrite;
  tFunc reqFunc;
  tWord reqData;
  logic busy;
  logic done;
  tWord rdData;
  logic [kl10Pkg::piLevelWidth-1:0] piLevel;

  // Reference state
  tWord aprModel [4];
  logic [6:0] piReqModel;
  logic [6:0] piEnModel;
  tWord lastRead;  // rdData holds until the next read

  tWord expRd[$];
  logic [2:0] expLevel[$];
  int errorCount = 0;
  int testCount = 0;
  int failedTests = 0;
  int errorsAtStart;
  string testName;
  int cycleCount = 0;

  kl10Ebus UUT (
    .clk(clk),
    .rst(rst),
    .reqStart(reqStart),
    .reqWrite(reqWrite),
    .reqFunc(reqFunc),
    .reqData(reqData),
    .busy(busy),
    .done(done),
    .rdData(rdData),
    .piLevel(piLevel)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic tWord randWord();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[kl10Pkg::ebusWidth-1:0];
  endfunction

  function automatic logic isAssigned(input tFunc code);
    case (code)
      kl10Pkg::fnAprWr0, kl10Pkg::fnAprWr1, kl10Pkg::fnAprWr2, kl10Pkg::fnAprWr3,
      kl10Pkg::fnAprRd0, kl10Pkg::fnAprRd1, kl10Pkg::fnAprRd2, kl10Pkg::fnAprRd3,
      kl10Pkg::fnPiWr, kl10Pkg::fnPiRd: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic tFunc pickUnassigned();
    tFunc code;
    do begin
      code = tFunc'($urandom());
    end while (isAssigned(code));
    return code;
  endfunction

  // Expected read word and PI level after one diagnostic cycle
  function automatic tWord refAccess(input logic wr, input tFunc func, input tWord data,
                                     output logic [2:0] level);
    logic [6:0] active;
    tWord word;
    if (wr) begin
      case (func)
        kl10Pkg::fnAprWr0: aprModel[0] = data;
        kl10Pkg::fnAprWr1: aprModel[1] = data;
        kl10Pkg::fnAprWr2: aprModel[2] = data;
        kl10Pkg::fnAprWr3: aprModel[3] = data;
        kl10Pkg::fnPiWr: begin
          piReqModel = data[6:0];
          piEnModel = data[14:8];
        end
        default: ;  // No board takes it
      endcase
    end
    active = piReqModel & piEnModel;
    level = 3'd0;
    for (int lvl = 1; lvl <= 7; lvl++) begin
      if (active[lvl-1] && level == 3'd0)
        level = 3'(lvl);
    end
    if (!wr) begin
      word = '0;
      case (func)
        kl10Pkg::fnAprRd0: word = aprModel[0];
        kl10Pkg::fnAprRd1: word = aprModel[1];
        kl10Pkg::fnAprRd2: word = aprModel[2];
        kl10Pkg::fnAprRd3: word = aprModel[3];
        kl10Pkg::fnPiRd: begin
          word[6:0] = active;
          word[14:8] = piEnModel;
          word[18:16] = level;
        end
        default: word = '0;  // Idle bus
      endcase
      lastRead = word;
    end
    return lastRead;
  endfunction

  task automatic checkValue(input string what, input tWord got, input tWord exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errorCount++;
    end
  endtask

  // One diagnostic cycle, optionally with a second start while busy
  task automatic runRequest(input logic wr, input tFunc func, input tWord data,
                            input logic pulseWhileBusy);
    tWord expWord;
    logic [2:0] expLvl;
    int waitCycles;
    expWord = refAccess(wr, func, data, expLvl);
    expRd.push_back(expWord);
    expLevel.push_back(expLvl);
    reqWrite = wr;
    reqFunc = func;
    reqData = data;
    reqStart = 1'b1;
    @(posedge clk);
    #10;
    reqStart = 1'b0;
    waitCycles = 1;
    checkValue("busy in setup", tWord'(busy), tWord'(1'b1));
    if (pulseWhileBusy) begin
      reqStart = 1'b1;
      reqWrite = 1'b1;
      reqFunc = kl10Pkg::fnAprWr0;
      reqData = ~aprModel[0];  // Would be visible if taken
    end
    while (!done && waitCycles < 8) begin
      @(posedge clk);
      #10;
      reqStart = 1'b0;
      waitCycles++;
    end
    if (!done) begin
      $display("Error at %0d ns: done never came for function %o", $time, func);
      errorCount++;
    end else if (waitCycles != 3) begin
      $display("Error at %0d ns: done came %0d cycles after start instead of 3",
               $time, waitCycles);
      errorCount++;
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    errorsAtStart = errorCount;
    testCount++;
  endtask

  task automatic endTest();
    int errs;
    @(posedge clk);
    #10;
    errs = errorCount - errorsAtStart;
    if (errs == 0) begin
      $display("Test %0d %s: passed", testCount, testName);
    end else begin
      $display("Test %0d %s: failed with %0d errors", testCount, testName, errs);
      failedTests++;
    end
  endtask

  // Compares every done cycle against the model
  always @(negedge clk) begin
    if (!rst && done) begin
      if (expRd.size() == 0) begin
        $display("Error at %0d ns: done pulse with no request outstanding", $time);
        errorCount++;
      end else begin
        checkValue("rdData", rdData, expRd.pop_front());
        checkValue("piLevel", tWord'(piLevel), tWord'(expLevel.pop_front()));
        checkValue("busy at done", tWord'(busy), '0);  // Finish takes a new start
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > timeoutCycles) begin
      $display("Timeout: run did not end within %0d cycles", timeoutCycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h5254));
    rst = 1'b1;
    reqStart = 1'b0;
    reqWrite = 1'b0;
    reqFunc = '0;
    reqData = '0;
    for (int i = 0; i < 4; i++) begin
      aprModel[i] = '0;
    end
    piReqModel = '0;
    piEnModel = '0;
    lastRead = '0;
    repeat (resetCycles) @(posedge clk);
    #10;
    rst = 1'b0;

    startTest("reset values");
    runRequest(1'b0, kl10Pkg::fnAprRd0, randWord(), 1'b0);
    runRequest(1'b0, kl10Pkg::fnAprRd1, randWord(), 1'b0);
    runRequest(1'b0, kl10Pkg::fnAprRd2, randWord(), 1'b0);
    runRequest(1'b0, kl10Pkg::fnAprRd3, randWord(), 1'b0);
    runRequest(1'b0, kl10Pkg::fnPiRd, randWord(), 1'b0);
    endTest();

    startTest("APR register write and read");
    for (int r = 0; r < aprRounds; r++) begin
      runRequest(1'b1, kl10Pkg::fnAprWr0, randWord(), 1'b0);
      runRequest(1'b1, kl10Pkg::fnAprWr1, randWord(), 1'b0);
      runRequest(1'b1, kl10Pkg::fnAprWr2, randWord(), 1'b0);
      runRequest(1'b1, kl10Pkg::fnAprWr3, randWord(), 1'b0);
      runRequest(1'b0, kl10Pkg::fnAprRd3, '0, 1'b0);
      runRequest(1'b0, kl10Pkg::fnAprRd2, '0, 1'b0);
      runRequest(1'b0, kl10Pkg::fnAprRd1, '0, 1'b0);
      runRequest(1'b0, kl10Pkg::fnAprRd0, '0, 1'b0);
    end
    endTest();

    startTest("PI requests and levels");
    for (int r = 0; r < piRounds; r++) begin
      runRequest(1'b1, kl10Pkg::fnPiWr, randWord(), 1'b0);
      runRequest(1'b0, kl10Pkg::fnPiRd, '0, 1'b0);
    end
    runRequest(1'b1, kl10Pkg::fnPiWr, tWord'(36'h0_0000_007f), 1'b0);  // All enables off
    runRequest(1'b0, kl10Pkg::fnPiRd, '0, 1'b0);
    endTest();

    startTest("unassigned function codes");
    for (int j = 0; j < junkCount; j++) begin
      runRequest(1'b1, pickUnassigned(), randWord(), 1'b0);
      runRequest(1'b0, kl10Pkg::fnAprRd0, '0, 1'b0);  // Nonzero word in rdData first
      runRequest(1'b0, pickUnassigned(), randWord(), 1'b0);
    end
    runRequest(1'b0, kl10Pkg::fnAprRd0, '0, 1'b0);
    runRequest(1'b0, kl10Pkg::fnAprRd1, '0, 1'b0);
    runRequest(1'b0, kl10Pkg::fnAprRd2, '0, 1'b0);
    runRequest(1'b0, kl10Pkg::fnAprRd3, '0, 1'b0);
    runRequest(1'b0, kl10Pkg::fnPiRd, '0, 1'b0);
    endTest();

    startTest("start while busy");
    runRequest(1'b0, kl10Pkg::fnAprRd1, '0, 1'b1);
    repeat (2) begin
      @(posedge clk);
      #10;
    end
    runRequest(1'b0, kl10Pkg::fnAprRd0, '0, 1'b0);
    endTest();

    if (expRd.size() != 0) begin
      $display("Error: %0d requests never reported done", expRd.size());
      errorCount++;
    end
    $display("Tests run %0d, tests failed %0d, errors %0d", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- project.f
source/kl10Pkg.sv
source/ebusFrontEnd.sv
source/aprDiagRegs.sv
source/piController.sv
source/ebusMux.sv
source/kl10Ebus.sv
testbench/kl10EbusTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = kl10EbusTb
FILELIST = project.f
OBJDIR   = obj_dir
PASSMSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Output is shown, then searched for the pass message
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
